// File: include/msu_macros.svh
`ifndef MSU_MACROS_SVH
`define MSU_MACROS_SVH

// buffer geometry
`define MSU_BUF_ADDR_W 14
`define MSU_BUF_DEPTH 16384

// console register map, reads
`define MSU_REG_STATUS 3'd0
`define MSU_REG_DATA 3'd1

// console register map, writes
`define MSU_REG_SEEK0 3'd0
`define MSU_REG_SEEK1 3'd1
`define MSU_REG_SEEK2 3'd2
`define MSU_REG_SEEK3 3'd3
`define MSU_REG_TRACK0 3'd4
`define MSU_REG_TRACK1 3'd5
`define MSU_REG_VOLUME 3'd6
`define MSU_REG_CONTROL 3'd7

// identity string "S-MSU1", regs 2..7
`define MSU_ID_2 8'h53
`define MSU_ID_3 8'h2d
`define MSU_ID_4 8'h4d
`define MSU_ID_5 8'h53
`define MSU_ID_6 8'h55
`define MSU_ID_7 8'h31

// low bits of status byte
`define MSU_REVISION 3'd1

// bit positions in set/reset masks
`define MSU_FLAG_AUDIO_BUSY 5
`define MSU_FLAG_DATA_BUSY 4
`define MSU_FLAG_AUDIO_ERROR 3
`define MSU_FLAG_AUDIO_STATUS_HI 2
`define MSU_FLAG_AUDIO_STATUS_LO 1
`define MSU_FLAG_CTRL_START 0

`endif

// File: hw/msu_pkg.sv
`include "msu_macros.svh"

package msu_pkg;

  // one register or buffer byte
  typedef logic [7:0] msu_byte_t;

  // buffer address, also the data pointer
  typedef logic [`MSU_BUF_ADDR_W-1:0] msu_buf_addr_t;

  // console register select
  typedef logic [2:0] msu_reg_sel_t;

  // seek target, four bytes assembled from regs 0..3
  typedef logic [31:0] msu_seek_addr_t;

  // track number from regs 4..5
  typedef logic [15:0] msu_track_t;

  // audio control field, low bits of reg 7
  typedef logic [2:0] msu_audio_ctrl_t;

  // audio status pair set by firmware
  typedef logic [1:0] msu_audio_status_t;

  // firmware set/reset masks, one bit per flag
  typedef logic [5:0] msu_flag_bits_t;

endpackage

// File: hw/msu_reg_bus_if.sv
`timescale 1ns/1ps

interface msu_reg_bus_if;
  import msu_pkg::*;

  // register access qualifier
  logic enable;
  // selected register, 0..7
  msu_reg_sel_t reg_addr;
  // console write data
  msu_byte_t reg_data_in;
  // single cycle strobes, edge detected upstream
  logic reg_oe_falling;
  logic reg_oe_rising;
  logic reg_we_rising;

  // register write decode
  modport writer (input enable, input reg_addr, input reg_data_in, input reg_we_rising);

  // read data capture
  modport reader (input enable, input reg_addr, input reg_oe_falling);

  // pointer advance on data reads
  modport pointer (input enable, input reg_addr, input reg_oe_rising);

endinterface

// File: hw/msu_data_buffer.sv
`timescale 1ns/1ps

`include "msu_macros.svh"

module msu_data_buffer (
  input  logic                   clkin,
  input  logic                   we,
  input  msu_pkg::msu_buf_addr_t waddr,
  input  msu_pkg::msu_byte_t     wdata,
  input  msu_pkg::msu_buf_addr_t raddr,
  output msu_pkg::msu_byte_t     rdata
);
  import msu_pkg::*;

  // streamed data, maps to block ram
  msu_byte_t mem [0:`MSU_BUF_DEPTH-1];

  // loader port, byte stored on this edge
  always_ff @(posedge clkin) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read
  // data valid one cycle after raddr moves
  always_ff @(posedge clkin) begin
    rdata <= mem[raddr];
  end

endmodule

// File: hw/msu_data_pointer.sv
`timescale 1ns/1ps

`include "msu_macros.svh"

module msu_data_pointer (
  input  logic                   clkin,
  input  logic                   reset,
  msu_reg_bus_if.pointer         bus,
  input  msu_pkg::msu_buf_addr_t ext_addr,
  input  logic                   ext_write,
  output msu_pkg::msu_buf_addr_t pointer
);
  import msu_pkg::*;

  // ext strobe history, oldest in bit 2
  logic [2:0] ext_write_sreg;
  logic       ext_write_rising;
  logic       data_read;

  // sample the strobe, comes from another domain
  always_ff @(posedge clkin) begin
    if (reset) begin
      ext_write_sreg <= 3'b000;
    end else begin
      ext_write_sreg <= {ext_write_sreg[1:0], ext_write};
    end
  end

  // edge between the two older stages
  assign ext_write_rising = (ext_write_sreg[2:1] == 2'b01);

  // console finished a read of the data reg
  assign data_read = bus.reg_oe_rising & bus.enable & (bus.reg_addr == `MSU_REG_DATA);

  // ext load beats increment
  always_ff @(posedge clkin) begin
    if (reset) begin
      pointer <= '0;
    end else if (ext_write_rising) begin
      pointer <= ext_addr;
    end else if (data_read) begin
      // wraps at top of buffer
      pointer <= pointer + msu_buf_addr_t'(1);
    end
  end

endmodule

// File: hw/msu_command_regs.sv
`timescale 1ns/1ps

`include "msu_macros.svh"

module msu_command_regs (
  input  logic                       clkin,
  input  logic                       reset,
  msu_reg_bus_if.writer              bus,
  input  msu_pkg::msu_flag_bits_t    status_set_bits,
  input  msu_pkg::msu_flag_bits_t    status_reset_bits,
  input  logic                       status_reset_we,
  output msu_pkg::msu_seek_addr_t    addr_out,
  output msu_pkg::msu_track_t        track_out,
  output msu_pkg::msu_byte_t         volume_out,
  output logic                       volume_latch,
  output msu_pkg::msu_audio_ctrl_t   audio_ctrl,
  output msu_pkg::msu_audio_status_t audio_status,
  output logic                       audio_start,
  output logic                       data_start,
  output logic                       ctrl_start,
  output logic                       audio_busy,
  output logic                       data_busy,
  output logic                       audio_error
);
  import msu_pkg::*;

  logic [1:0] status_we_sreg;
  logic       status_update;
  logic       reg_write;

  //////////////////////////////////////////////////
  // firmware status strobe
  //////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      status_we_sreg <= 2'b00;
    end else begin
      status_we_sreg <= {status_we_sreg[0], status_reset_we};
    end
  end

  // one cycle pulse on rising edge
  assign status_update = (status_we_sreg == 2'b01);

  // console write, only while selected
  assign reg_write = bus.reg_we_rising & bus.enable;

  //////////////////////////////////////////////////
  // register file and flags
  //////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      addr_out     <= '0;
      track_out    <= '0;
      volume_out   <= '0;
      volume_latch <= 1'b0;
      audio_ctrl   <= '0;
      audio_status <= '0;
      audio_start  <= 1'b0;
      data_start   <= 1'b0;
      ctrl_start   <= 1'b0;
      audio_error  <= 1'b0;
      // nothing playing or streaming until firmware says so
      audio_busy   <= 1'b1;
      data_busy    <= 1'b1;
    end else if (reg_write) begin
      case (bus.reg_addr)
        `MSU_REG_SEEK0: addr_out[7:0] <= bus.reg_data_in;
        `MSU_REG_SEEK1: addr_out[15:8] <= bus.reg_data_in;
        `MSU_REG_SEEK2: addr_out[23:16] <= bus.reg_data_in;
        `MSU_REG_SEEK3: begin
          // top byte kicks off the seek
          addr_out[31:24] <= bus.reg_data_in;
          data_start      <= 1'b1;
          data_busy       <= 1'b1;
        end
        `MSU_REG_TRACK0: track_out[7:0] <= bus.reg_data_in;
        `MSU_REG_TRACK1: begin
          // high byte starts the track load
          track_out[15:8] <= bus.reg_data_in;
          audio_start     <= 1'b1;
          audio_busy      <= 1'b1;
        end
        `MSU_REG_VOLUME: begin
          volume_out   <= bus.reg_data_in;
          volume_latch <= 1'b1;
        end
        `MSU_REG_CONTROL: begin
          // dropped while a track is still loading
          if (!audio_busy) begin
            audio_ctrl <= bus.reg_data_in[2:0];
            ctrl_start <= 1'b1;
          end
        end
        default: ;
      endcase
    end else if (status_update) begin
      // flag = (old | set) & ~reset
      audio_busy <= (audio_busy | status_set_bits[`MSU_FLAG_AUDIO_BUSY])
                    & ~status_reset_bits[`MSU_FLAG_AUDIO_BUSY];
      data_busy <= (data_busy | status_set_bits[`MSU_FLAG_DATA_BUSY])
                   & ~status_reset_bits[`MSU_FLAG_DATA_BUSY];
      audio_error <= (audio_error | status_set_bits[`MSU_FLAG_AUDIO_ERROR])
                     & ~status_reset_bits[`MSU_FLAG_AUDIO_ERROR];
      audio_status <= (audio_status
                       | status_set_bits[`MSU_FLAG_AUDIO_STATUS_HI:`MSU_FLAG_AUDIO_STATUS_LO])
                      & ~status_reset_bits[`MSU_FLAG_AUDIO_STATUS_HI:`MSU_FLAG_AUDIO_STATUS_LO];
      ctrl_start <= (ctrl_start | status_set_bits[`MSU_FLAG_CTRL_START])
                    & ~status_reset_bits[`MSU_FLAG_CTRL_START];
      // clearing busy also retires the start request
      if (status_reset_bits[`MSU_FLAG_AUDIO_BUSY]) begin
        audio_start <= 1'b0;
      end
      if (status_reset_bits[`MSU_FLAG_DATA_BUSY]) begin
        data_start <= 1'b0;
      end
    end else begin
      // volume latch lasts until an idle cycle
      volume_latch <= 1'b0;
    end
  end

endmodule

// File: hw/msu_reg_read.sv
`timescale 1ns/1ps

`include "msu_macros.svh"

module msu_reg_read (
  input  logic                       clkin,
  input  logic                       reset,
  msu_reg_bus_if.reader              bus,
  input  msu_pkg::msu_byte_t         buf_data,
  input  logic                       data_busy,
  input  logic                       audio_busy,
  input  logic                       audio_error,
  input  msu_pkg::msu_audio_status_t audio_status,
  output msu_pkg::msu_byte_t         reg_data_out
);
  import msu_pkg::*;

  logic      read_strobe;
  msu_byte_t status_byte;
  msu_byte_t read_value;

  // start of a console read cycle
  assign read_strobe = bus.reg_oe_falling & bus.enable;

  // busy flags on top, revision in low bits
  assign status_byte = {data_busy, audio_busy, audio_status, audio_error, `MSU_REVISION};

  // read mux
  always_comb begin
    case (bus.reg_addr)
      `MSU_REG_STATUS: read_value = status_byte;
      `MSU_REG_DATA:   read_value = buf_data;
      // identity string
      3'd2:            read_value = `MSU_ID_2;
      3'd3:            read_value = `MSU_ID_3;
      3'd4:            read_value = `MSU_ID_4;
      3'd5:            read_value = `MSU_ID_5;
      3'd6:            read_value = `MSU_ID_6;
      default:         read_value = `MSU_ID_7;
    endcase
  end

  // captured once per read, holds until next one
  always_ff @(posedge clkin) begin
    if (reset) begin
      reg_data_out <= '0;
    end else if (read_strobe) begin
      reg_data_out <= read_value;
    end
  end

endmodule

// File: hw/msu.sv
`timescale 1ns/1ps

`include "msu_macros.svh"

module msu (
  input  logic                     clkin,
  input  logic                     reset,
  input  logic                     enable,
  input  msu_pkg::msu_buf_addr_t   pgm_address,
  input  msu_pkg::msu_byte_t       pgm_data,
  input  logic                     pgm_we,
  input  msu_pkg::msu_reg_sel_t    reg_addr,
  input  msu_pkg::msu_byte_t       reg_data_in,
  input  logic                     reg_oe_falling,
  input  logic                     reg_oe_rising,
  input  logic                     reg_we_rising,
  input  msu_pkg::msu_flag_bits_t  status_set_bits,
  input  msu_pkg::msu_flag_bits_t  status_reset_bits,
  input  logic                     status_reset_we,
  input  msu_pkg::msu_buf_addr_t   msu_address_ext,
  input  logic                     msu_address_ext_write,
  output msu_pkg::msu_byte_t       reg_data_out,
  output msu_pkg::msu_byte_t       status_out,
  output msu_pkg::msu_byte_t       volume_out,
  output logic                     volume_latch_out,
  output msu_pkg::msu_seek_addr_t  addr_out,
  output msu_pkg::msu_track_t      track_out
);
  import msu_pkg::*;

  msu_buf_addr_t     data_pointer;
  msu_byte_t         buf_data;
  msu_audio_ctrl_t   audio_ctrl;
  msu_audio_status_t audio_status;
  logic              audio_start;
  logic              data_start;
  logic              ctrl_start;
  logic              audio_busy;
  logic              data_busy;
  logic              audio_error;

  //////////////////////////////////////////////////
  // console register bus
  //////////////////////////////////////////////////

  msu_reg_bus_if reg_bus ();

  assign reg_bus.enable         = enable;
  assign reg_bus.reg_addr       = reg_addr;
  assign reg_bus.reg_data_in    = reg_data_in;
  assign reg_bus.reg_oe_falling = reg_oe_falling;
  assign reg_bus.reg_oe_rising  = reg_oe_rising;
  assign reg_bus.reg_we_rising  = reg_we_rising;

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////

  // loader owns the write port, pointer the read port
  msu_data_buffer data_buffer (
    .clkin (clkin),
    .we    (pgm_we),
    .waddr (pgm_address),
    .wdata (pgm_data),
    .raddr (data_pointer),
    .rdata (buf_data)
  );

  msu_data_pointer data_ptr (
    .clkin     (clkin),
    .reset     (reset),
    .bus       (reg_bus.pointer),
    .ext_addr  (msu_address_ext),
    .ext_write (msu_address_ext_write),
    .pointer   (data_pointer)
  );

  //////////////////////////////////////////////////
  // registers and read back
  //////////////////////////////////////////////////

  msu_command_regs command_regs (
    .clkin             (clkin),
    .reset             (reset),
    .bus               (reg_bus.writer),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .status_reset_we   (status_reset_we),
    .addr_out          (addr_out),
    .track_out         (track_out),
    .volume_out        (volume_out),
    .volume_latch      (volume_latch_out),
    .audio_ctrl        (audio_ctrl),
    .audio_status      (audio_status),
    .audio_start       (audio_start),
    .data_start        (data_start),
    .ctrl_start        (ctrl_start),
    .audio_busy        (audio_busy),
    .data_busy         (data_busy),
    .audio_error       (audio_error)
  );

  msu_reg_read reg_read (
    .clkin        (clkin),
    .reset        (reset),
    .bus          (reg_bus.reader),
    .buf_data     (buf_data),
    .data_busy    (data_busy),
    .audio_busy   (audio_busy),
    .audio_error  (audio_error),
    .audio_status (audio_status),
    .reg_data_out (reg_data_out)
  );

  // cartridge side status, pointer msb marks upper half of buffer
  assign status_out = {data_pointer[`MSU_BUF_ADDR_W-1],
                       audio_start,
                       data_start,
                       volume_latch_out,
                       audio_ctrl,
                       ctrl_start};

endmodule

// File: verif/msu_clock_gen.sv
`timescale 1ns/1ps

module msu_clock_gen (
  output logic clkin
);

  // half of the 100 ns period
  localparam int HALF_PERIOD_NS = 50;

  // free running, starts low
  initial begin
    clkin = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clkin = ~clkin;
    end
  end

endmodule

// File: verif/msu_tb.sv
`timescale 1ns/1ps

`include "msu_macros.svh"

module msu_tb;
  import msu_pkg::*;

  localparam int RESET_CYCLES    = 16;
  localparam int CLK_PERIOD_NS   = 100;
  localparam int CYCLES_PER_LINE = 12;
  localparam int DRIVE_DELAY_NS  = 5;
  localparam string VECTOR_FILE  = "verif/msu_vectors.txt";

  logic              clkin;
  logic              reset;
  logic              enable;
  msu_buf_addr_t     pgm_address;
  msu_byte_t         pgm_data;
  logic              pgm_we;
  msu_reg_sel_t      reg_addr;
  msu_byte_t         reg_data_in;
  logic              reg_oe_falling;
  logic              reg_oe_rising;
  logic              reg_we_rising;
  msu_flag_bits_t    status_set_bits;
  msu_flag_bits_t    status_reset_bits;
  logic              status_reset_we;
  msu_buf_addr_t     msu_address_ext;
  logic              msu_address_ext_write;
  msu_byte_t         reg_data_out;
  msu_byte_t         status_out;
  msu_byte_t         volume_out;
  logic              volume_latch_out;
  msu_seek_addr_t    addr_out;
  msu_track_t        track_out;

  // mirror of buffer contents and read pointer
  msu_byte_t         buf_model [0:`MSU_BUF_DEPTH-1];
  msu_buf_addr_t     ptr_model;

  int                test_errors;
  int                total_errors;
  int                tests_run;
  int                tests_failed;
  longint            timeout_ns;

  msu_clock_gen clock_gen (.clkin(clkin));

  msu msu_inst (
    .clkin                 (clkin),
    .reset                 (reset),
    .enable                (enable),
    .pgm_address           (pgm_address),
    .pgm_data              (pgm_data),
    .pgm_we                (pgm_we),
    .reg_addr              (reg_addr),
    .reg_data_in           (reg_data_in),
    .reg_oe_falling        (reg_oe_falling),
    .reg_oe_rising         (reg_oe_rising),
    .reg_we_rising         (reg_we_rising),
    .status_set_bits       (status_set_bits),
    .status_reset_bits     (status_reset_bits),
    .status_reset_we       (status_reset_we),
    .msu_address_ext       (msu_address_ext),
    .msu_address_ext_write (msu_address_ext_write),
    .reg_data_out          (reg_data_out),
    .status_out            (status_out),
    .volume_out            (volume_out),
    .volume_latch_out      (volume_latch_out),
    .addr_out              (addr_out),
    .track_out             (track_out)
  );

  //////////////////////////////////////////////////
  // bus tasks
  //////////////////////////////////////////////////

  // inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clkin);
    #(DRIVE_DELAY_NS);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] %0s: expected %0h, got %0h", sig, expected, actual);
    test_errors++;
  endtask

  // console write strobe for one cycle then settle
  task automatic write_reg(input logic en, input msu_reg_sel_t sel, input msu_byte_t data);
    enable        = en;
    reg_addr      = sel;
    reg_data_in   = data;
    reg_we_rising = 1'b1;
    next_cycle();
    reg_we_rising = 1'b0;
    wait_cycles(4);
  endtask

  // console read with oe falling then rising
  task automatic read_reg(input logic en, input msu_reg_sel_t sel, output msu_byte_t data);
    enable         = en;
    reg_addr       = sel;
    reg_oe_falling = 1'b1;
    next_cycle();
    reg_oe_falling = 1'b0;
    next_cycle();
    reg_oe_rising  = 1'b1;
    next_cycle();
    reg_oe_rising  = 1'b0;
    wait_cycles(4);
    data = reg_data_out;
  endtask

  // random bytes through the loader port
  task automatic load_bytes(input msu_buf_addr_t start, input int count);
    msu_buf_addr_t a;
    a = start;
    for (int i = 0; i < count; i++) begin
      pgm_address = a;
      pgm_data    = $urandom % 256;
      pgm_we      = 1'b1;
      buf_model[a] = pgm_data;
      next_cycle();
      a = a + 1;
    end
    pgm_we = 1'b0;
    next_cycle();
  endtask

  // strobe held high long enough for the sync chain
  task automatic ext_load(input msu_buf_addr_t addr);
    msu_address_ext       = addr;
    msu_address_ext_write = 1'b1;
    wait_cycles(3);
    msu_address_ext_write = 1'b0;
    wait_cycles(4);
    ptr_model = addr;
  endtask

  // firmware flag update with masks left driven
  task automatic status_update(input msu_flag_bits_t set_bits, input msu_flag_bits_t clr_bits);
    status_set_bits   = set_bits;
    status_reset_bits = clr_bits;
    status_reset_we   = 1'b1;
    wait_cycles(2);
    status_reset_we   = 1'b0;
    wait_cycles(4);
  endtask

  //////////////////////////////////////////////////
  // vector decode
  //////////////////////////////////////////////////

  task automatic exec_vector(input logic [8*128-1:0] text);
    logic [8*16-1:0] op;
    logic [8*24-1:0] name;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    logic [31:0]     d;
    logic [31:0]     e;
    msu_byte_t       got;
    msu_byte_t       expected;
    int              code;
    op   = '0;
    code = $sscanf(text, "%s", op);
    // blank line or comment
    if (code < 1 || op == "#") begin
    end else if (op == "load") begin
      code = $sscanf(text, "%s %h %h", op, a, b);
      load_bytes(a[`MSU_BUF_ADDR_W-1:0], b);
    end else if (op == "ext") begin
      code = $sscanf(text, "%s %h", op, a);
      ext_load(a[`MSU_BUF_ADDR_W-1:0]);
    end else if (op == "write") begin
      code = $sscanf(text, "%s %h %h %h", op, a, b, c);
      write_reg(a[0], b[2:0], c[7:0]);
    end else if (op == "read") begin
      code = $sscanf(text, "%s %h %h %h", op, a, b, c);
      read_reg(a[0], b[2:0], got);
      // data reg value comes from the model and the pointer advances
      if (a[0] && b[2:0] == `MSU_REG_DATA) begin
        expected  = buf_model[ptr_model];
        ptr_model = ptr_model + 1;
      end else begin
        expected = c[7:0];
      end
      if (got !== expected) begin
        report_mismatch($sformatf("reg_data_out (reg %0d)", b[2:0]), expected, got);
      end
    end else if (op == "status") begin
      code = $sscanf(text, "%s %h %h", op, a, b);
      status_update(a[5:0], b[5:0]);
    end else if (op == "check") begin
      code = $sscanf(text, "%s %h %h %h %h %h", op, a, b, c, d, e);
      if (addr_out !== a) begin
        report_mismatch("addr_out", a, addr_out);
      end
      if (track_out !== b[15:0]) begin
        report_mismatch("track_out", b, track_out);
      end
      if (volume_out !== c[7:0]) begin
        report_mismatch("volume_out", c, volume_out);
      end
      if (volume_latch_out !== d[0]) begin
        report_mismatch("volume_latch_out", d, volume_latch_out);
      end
      if (status_out !== e[7:0]) begin
        report_mismatch("status_out", e, status_out);
      end
    end else if (op == "end") begin
      code = $sscanf(text, "%s %s", op, name);
      tests_run++;
      if (test_errors == 0) begin
        $display("test %0s: ok", name);
      end else begin
        $display("test %0s: %0d errors", name, test_errors);
        tests_failed++;
      end
      total_errors += test_errors;
      test_errors = 0;
    end else begin
      $display("unknown opcode in vector file: %0s", op);
      test_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : run
    int               fd;
    int               code;
    int               lines;
    int               seed_val;
    logic [8*128-1:0] line_buf;
    // every input defined from time zero
    reset                 = 1'b1;
    enable                = 1'b0;
    pgm_address           = '0;
    pgm_data              = '0;
    pgm_we                = 1'b0;
    reg_addr              = '0;
    reg_data_in           = '0;
    reg_oe_falling        = 1'b0;
    reg_oe_rising         = 1'b0;
    reg_we_rising         = 1'b0;
    status_set_bits       = '0;
    status_reset_bits     = '0;
    status_reset_we       = 1'b0;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    ptr_model             = '0;
    test_errors           = 0;
    total_errors          = 0;
    tests_run             = 0;
    tests_failed          = 0;
    timeout_ns            = 0;

    // size the watchdog from the vector count
    lines = 0;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      $display("could not open vector file %0s", VECTOR_FILE);
      total_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line_buf, fd);
        if (code > 0) begin
          lines++;
        end
      end
      $fclose(fd);
    end
    timeout_ns = (longint'(lines) * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD_NS;

    wait_cycles(RESET_CYCLES);
    reset = 1'b0;
    seed_val = $urandom(32'hbfcad6a1);
    next_cycle();

    if (lines > 0) begin
      fd = $fopen(VECTOR_FILE, "r");
      while (!$feof(fd)) begin
        line_buf = '0;
        code = $fgets(line_buf, fd);
        if (code > 0) begin
          exec_vector(line_buf);
        end
      end
      $fclose(fd);
    end

    // errors after the last end line still count
    total_errors += test_errors;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0 && tests_run > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // run limit armed once the vector count is known
  initial begin : watchdog
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("timeout: vectors did not finish within %0d ns", timeout_ns);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: verif/msu_vectors.txt
# load addr count | ext addr | write en reg data | read en reg expect | status set reset
# check addr track volume latch status_out | end name; reg 1 expect column unused
read 1 2 53
read 1 3 2d
read 1 4 4d
read 1 5 53
read 1 6 55
read 1 7 31
read 1 0 c1
end identity
load 1ffe 6
ext 1ffe
check 00000000 0000 00 0 00
read 1 1 00
read 1 1 00
check 00000000 0000 00 0 80
read 1 1 00
read 1 1 00
check 00000000 0000 00 0 80
ext 0000
check 00000000 0000 00 0 00
end streaming
status 00 10
read 1 0 41
write 0 0 11
write 0 1 22
write 0 2 33
write 0 3 44
check 00000000 0000 00 0 00
write 1 0 78
write 1 1 56
write 1 2 34
write 1 3 12
check 12345678 0000 00 0 20
read 1 0 c1
status 00 10
check 12345678 0000 00 0 00
read 1 0 41
end seek
write 1 4 cd
write 1 5 ab
check 12345678 abcd 00 0 40
write 1 6 7f
check 12345678 abcd 7f 0 40
end track_volume
write 1 7 05
check 12345678 abcd 7f 0 40
status 00 20
check 12345678 abcd 7f 0 00
read 1 0 01
write 1 7 fd
check 12345678 abcd 7f 0 0b
end control
status 0e 00
read 1 0 39
status 00 0e
read 1 0 01
status 0a 00
read 1 0 19
status 30 08
read 1 0 d1
check 12345678 abcd 7f 0 0b
end flags

// File: sources.f
+incdir+include
hw/msu_pkg.sv
hw/msu_reg_bus_if.sv
hw/msu_data_buffer.sv
hw/msu_data_pointer.sv
hw/msu_command_regs.sv
hw/msu_reg_read.sv
hw/msu.sv
verif/msu_clock_gen.sv
verif/msu_tb.sv

// File: Bender.yml
package:
  name: msu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/msu_pkg.sv
      - hw/msu_reg_bus_if.sv
      - hw/msu_data_buffer.sv
      - hw/msu_data_pointer.sv
      - hw/msu_command_regs.sv
      - hw/msu_reg_read.sv
      - hw/msu.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/msu_clock_gen.sv
      - verif/msu_tb.sv
